/* mem_ex_latch.f */
src/mem_ex_pkg.sv
src/wakeup_slot.sv
src/operand_wakeup.sv
src/queue_nm.sv
src/mem_ex_latch_top.sv
tests/mem_ex_latch_sva.sv
tests/mem_ex_latch_tb.sv

/* tests/mem_ex_latch_tb.sv */
module mem_ex_latch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_ex_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 5;
    localparam logic [31:0] SEED = 32'h6cfa_2dc5;

    logic              clk;
    logic              arst_n;
    logic              wr;
    logic              rd;
    logic              clr;
    logic [M_W-1:0]    in_m;
    logic [N_W-1:0]    in_n;
    logic              res_valid;
    logic [TAG_W-1:0]  res_tag;
    logic [VAL_W-1:0]  res_val;
    logic              full;
    logic              empty;
    logic [CNT_W-1:0]  count;
    logic [E_W-1:0]    dout;

    // reference queue with the head at index 0
    logic [E_W-1:0]    model_q [$];
    logic [31:0]       lfsr_state;

    mem_ex_latch_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .in_m      (in_m),
        .in_n      (in_n),
        .rd        (rd),
        .clr       (clr),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_val   (res_val),
        .full      (full),
        .empty     (empty),
        .count     (count),
        .dout      (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // pack two operands plus valid from the package offsets
    function automatic logic [M_W-1:0] make_m(
        input logic w0, input logic [TAG_W-1:0] t0, input logic [VAL_W-1:0] v0,
        input logic w1, input logic [TAG_W-1:0] t1, input logic [VAL_W-1:0] v1);
        logic [M_W-1:0] m;
        m = '0;
        m[WAIT_OFS]                   = w0;
        m[TAG_OFS +: TAG_W]           = t0;
        m[VAL_OFS +: VAL_W]           = v0;
        m[OP_W + WAIT_OFS]            = w1;
        m[OP_W + TAG_OFS +: TAG_W]    = t1;
        m[OP_W + VAL_OFS +: VAL_W]    = v1;
        m[VALID_BIT]                  = 1'b1;
        return m;
    endfunction

    // entry with both operands ready
    function automatic logic [M_W-1:0] ready_m();
        logic [TAG_W-1:0] t0;
        logic [TAG_W-1:0] t1;
        logic [VAL_W-1:0] v0;
        logic [VAL_W-1:0] v1;
        t0 = TAG_W'(rand_bits(TAG_W));
        v0 = rand_bits(VAL_W);
        t1 = TAG_W'(rand_bits(TAG_W));
        v1 = rand_bits(VAL_W);
        return make_m(1'b0, t0, v0, 1'b0, t1, v1);
    endfunction

    // waiting operand with an equal tag takes the broadcast value
    function automatic logic [M_W-1:0] wake_m(input logic [M_W-1:0] m, input logic rv,
                                              input logic [TAG_W-1:0] rtag,
                                              input logic [VAL_W-1:0] rval);
        logic [M_W-1:0] r;
        int             base;
        r = m;
        for (int k = 0; k < NUM_OPS; k++) begin
            base = k * OP_W;
            if (rv && m[base + WAIT_OFS] && (m[base + TAG_OFS +: TAG_W] == rtag)) begin
                r[base + VAL_OFS +: VAL_W] = rval;
                r[base + WAIT_OFS]         = 1'b0;
            end
        end
        return r;
    endfunction

    task automatic check_entry(input string name, input logic [E_W-1:0] exp,
                               input logic [E_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "head entry mismatch in %s", name);
        end
    endtask

    task automatic check_flags(input string name, input logic exp_full,
                               input logic exp_empty, input logic [CNT_W-1:0] exp_cnt,
                               input logic act_full, input logic act_empty,
                               input logic [CNT_W-1:0] act_cnt);
        if ({act_full, act_empty, act_cnt} !== {exp_full, exp_empty, exp_cnt}) begin
            $display("Fail %s: expected full=%0b empty=%0b count=%0d, %s",
                     name, exp_full, exp_empty, exp_cnt,
                     $sformatf("got full=%0b empty=%0b count=%0d",
                               act_full, act_empty, act_cnt));
            $display("TESTS FAILED");
            $fatal(1, "status flag mismatch in %s", name);
        end
    endtask

    // the DUT takes these inputs at the next edge
    task automatic drive_cycle(input logic wr_v, input logic rd_v, input logic clr_v,
                               input logic [M_W-1:0] m, input logic [N_W-1:0] n,
                               input logic rv, input logic [TAG_W-1:0] rtag,
                               input logic [VAL_W-1:0] rval);
        logic wr_ok;
        logic rd_ok;
        @(posedge clk);
        wr        <= wr_v;
        rd        <= rd_v;
        clr       <= clr_v;
        in_m      <= m;
        in_n      <= n;
        res_valid <= rv;
        res_tag   <= rtag;
        res_val   <= rval;
        if (clr_v) begin
            model_q.delete();
        end else begin
            // full and empty judged on the state before the edge
            wr_ok = wr_v && (model_q.size() < Q_LEN);
            rd_ok = rd_v && (model_q.size() > 0);
            foreach (model_q[i]) begin
                model_q[i] = {wake_m(model_q[i][E_W-1 -: M_W], rv, rtag, rval),
                              model_q[i][N_W-1:0]};
            end
            if (rd_ok) begin
                void'(model_q.pop_front());
            end
            if (wr_ok) begin
                model_q.push_back({wake_m(m, rv, rtag, rval), n});
            end
        end
    endtask

    task automatic write_entry(input logic [M_W-1:0] m, input logic [N_W-1:0] n);
        drive_cycle(1'b1, 1'b0, 1'b0, m, n, 1'b0, '0, '0);
    endtask

    task automatic read_entry();
        drive_cycle(1'b0, 1'b1, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // idle edge then compare at the falling edge
    task automatic check_state(input string name);
        logic [E_W-1:0]   exp_dout;
        logic [CNT_W-1:0] exp_cnt;
        drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
        @(negedge clk);
        exp_cnt  = CNT_W'(model_q.size());
        exp_dout = (model_q.size() == 0) ? '0 : model_q[0];
        check_entry(name, exp_dout, dout);
        check_flags(name, exp_cnt == CNT_W'(Q_LEN), exp_cnt == '0, exp_cnt,
                    full, empty, count);
    endtask

    // read out everything and check the head each time
    task automatic drain(input string name);
        while (model_q.size() > 0) begin
            check_state(name);
            read_entry();
        end
        check_state(name);
    endtask

    task automatic test_reset_order();
        check_state("test_reset_order");
        check_flags("test_reset_order", 1'b0, 1'b1, '0, full, empty, count);
        for (int j = 0; j < 5; j++) begin
            write_entry(ready_m(), rand_bits(N_W));
        end
        drain("test_reset_order");
    endtask

    task automatic test_full_drop();
        for (int j = 0; j < Q_LEN; j++) begin
            write_entry(ready_m(), rand_bits(N_W));
        end
        check_state("test_full_drop");
        check_flags("test_full_drop", 1'b1, 1'b0, CNT_W'(Q_LEN), full, empty, count);
        // ninth write goes nowhere
        write_entry(ready_m(), rand_bits(N_W));
        check_state("test_full_drop");
        // write still dropped with a read in the same full cycle
        drive_cycle(1'b1, 1'b1, 1'b0, ready_m(), rand_bits(N_W), 1'b0, '0, '0);
        check_state("test_full_drop");
        drain("test_full_drop");
    endtask

    task automatic test_wakeup_queued();
        logic [TAG_W-1:0] hit_tag;
        logic [TAG_W-1:0] t0;
        logic [TAG_W-1:0] t1;
        logic [VAL_W-1:0] rval;
        hit_tag = TAG_W'(rand_bits(TAG_W));
        rval    = rand_bits(VAL_W);
        for (int j = 0; j < 6; j++) begin
            // even slots wait on the hit tag in op0
            t0 = (j % 2 == 0) ? hit_tag : hit_tag ^ TAG_W'(5);
            t1 = (j % 3 == 0) ? hit_tag : hit_tag ^ TAG_W'(j + 1);
            // j == 3 has the hit tag in op1 but is not waiting
            write_entry(make_m(1'b1, t0, rand_bits(VAL_W), j != 3, t1, rand_bits(VAL_W)),
                        rand_bits(N_W));
        end
        check_state("test_wakeup_queued");
        drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, hit_tag, rval);
        check_state("test_wakeup_queued");
        drain("test_wakeup_queued");
    endtask

    task automatic test_wakeup_on_write();
        logic [TAG_W-1:0] hit_tag;
        logic [VAL_W-1:0] rval;
        logic [M_W-1:0]   m;
        hit_tag = TAG_W'(rand_bits(TAG_W));
        rval    = rand_bits(VAL_W);
        // broadcast in the write cycle into an empty queue
        m = make_m(1'b1, hit_tag, rand_bits(VAL_W), 1'b1, hit_tag ^ TAG_W'(3), rand_bits(VAL_W));
        drive_cycle(1'b1, 1'b0, 1'b0, m, rand_bits(N_W), 1'b1, hit_tag, rval);
        check_state("test_wakeup_on_write");
        // stored entry and incoming entry hit by the same broadcast
        rval = rand_bits(VAL_W);
        write_entry(make_m(1'b0, hit_tag, rand_bits(VAL_W), 1'b1, hit_tag, rand_bits(VAL_W)),
                    rand_bits(N_W));
        m = make_m(1'b1, hit_tag, rand_bits(VAL_W), 1'b1, hit_tag, rand_bits(VAL_W));
        drive_cycle(1'b1, 1'b0, 1'b0, m, rand_bits(N_W), 1'b1, hit_tag, rval);
        check_state("test_wakeup_on_write");
        drain("test_wakeup_on_write");
    endtask

    task automatic test_flush_wrap();
        logic wr_v;
        logic rd_v;
        for (int step = 0; step < 24; step++) begin
            if (step == 12) begin
                // flush with a write in the same cycle
                drive_cycle(1'b1, 1'b0, 1'b1, ready_m(), rand_bits(N_W), 1'b0, '0, '0);
                check_state("test_flush_wrap");
                check_flags("test_flush_wrap", 1'b0, 1'b1, '0, full, empty, count);
            end else begin
                // writes three times out of four and reads half the time
                wr_v = (rand_bits(2) != 0);
                rd_v = rand_bits(1) != 0;
                drive_cycle(wr_v, rd_v, 1'b0, ready_m(), rand_bits(N_W), 1'b0, '0, '0);
                check_state("test_flush_wrap");
            end
        end
        for (int j = 0; j < 3; j++) begin
            write_entry(ready_m(), rand_bits(N_W));
        end
        drain("test_flush_wrap");
    endtask

    // watchdog sized from the number of tests
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("TESTS FAILED");
        $fatal(1, "timeout: the tests did not finish in the allowed time");
    end

    // stop at the first failed queue assertion
    always @(negedge clk) begin
        if (dut0.q0.sva0.fail_cnt != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "a queue assertion failed, see the error above");
        end
    end

    initial begin
        lfsr_state = SEED;
        arst_n     = 1'b0;
        wr         = 1'b0;
        rd         = 1'b0;
        clr        = 1'b0;
        in_m       = '0;
        in_n       = '0;
        res_valid  = 1'b0;
        res_tag    = '0;
        res_val    = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_order();
        test_full_drop();
        test_wakeup_queued();
        test_wakeup_on_write();
        test_flush_wrap();

        if (dut0.q0.sva0.fail_cnt != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "a queue assertion failed during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* tests/mem_ex_latch_sva.sv */
module mem_ex_latch_sva (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wr,
    input  logic                           rd,
    input  logic                           clr,
    input  logic                           full,
    input  logic                           empty,
    input  logic [mem_ex_pkg::CNT_W-1:0]   count
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_ex_pkg::*;

    // running total of assertion failures
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // full and empty never together
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(full && empty)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("queue reports full and empty at the same time");
    end

    // occupancy bounded by the slot count
    a_count_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(Q_LEN)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("queue count exceeds the number of slots");
    end

    // write while full with no read or flush leaves count alone
    a_drop_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wr && full && !rd && !clr) |=> (count == $past(count))
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("write while full changed the count");
    end

    // flush lands on the next edge
    a_clr_empties: assert property (
        @(posedge clk) disable iff (!arst_n)
        clr |=> empty
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("queue not empty one cycle after clr");
    end

endmodule

// hook onto every queue instance
bind queue_nm mem_ex_latch_sva sva0 (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .rd     (rd),
    .clr    (clr),
    .full   (full),
    .empty  (empty),
    .count  (count)
);

/* src/mem_ex_latch_top.sv */
module mem_ex_latch_top (
    input  logic                           clk,
    input  logic                           arst_n,
    // memory stage side
    input  logic                           wr,
    input  logic [mem_ex_pkg::M_W-1:0]     in_m,
    input  logic [mem_ex_pkg::N_W-1:0]     in_n,
    // execute stage side
    input  logic                           rd,
    // flush
    input  logic                           clr,
    // result bus from later stages
    input  logic                           res_valid,
    input  logic [mem_ex_pkg::TAG_W-1:0]   res_tag,
    input  logic [mem_ex_pkg::VAL_W-1:0]   res_val,
    // status and head entry toward execute
    output logic                           full,
    output logic                           empty,
    output logic [mem_ex_pkg::CNT_W-1:0]   count,
    output logic [mem_ex_pkg::E_W-1:0]     dout
);

    import mem_ex_pkg::*;

    // queue to wakeup, all slots' modifiable parts
    logic [MVEC_W-1:0] old_m_vector;
    // wakeup to queue, patched slots
    logic [MVEC_W-1:0] new_m_vector;
    // which slots take their patched copy
    logic [Q_LEN-1:0]  modify_vector;
    // incoming modifiable part after same-cycle wakeup
    logic [M_W-1:0]    woken_m_din;

    // storage, pointers and flags
    queue_nm q0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (wr),
        .rd            (rd),
        .clr           (clr),
        // write path goes through the extra matcher first
        .m_din         (woken_m_din),
        // control bits never touch the wakeup logic
        .n_din         (in_n),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .full          (full),
        .empty         (empty),
        .count         (count),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    // combinational operand fill from the result bus
    // stored entries see it one edge later
    operand_wakeup wake0 (
        .old_m_vector  (old_m_vector),
        .m_din         (in_m),
        .res_valid     (res_valid),
        .res_tag       (res_tag),
        .res_val       (res_val),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .woken_m_din   (woken_m_din)
    );

endmodule

/* src/queue_nm.sv */
module queue_nm (
    input  logic                              clk,
    input  logic                              arst_n,
    // one-cycle strobes from the stages
    input  logic                              wr,
    input  logic                              rd,
    // synchronous flush
    input  logic                              clr,
    // entry coming in from the memory stage
    input  logic [mem_ex_pkg::M_W-1:0]        m_din,
    input  logic [mem_ex_pkg::N_W-1:0]        n_din,
    // in-place update of waiting entries
    input  logic [mem_ex_pkg::MVEC_W-1:0]     new_m_vector,
    input  logic [mem_ex_pkg::Q_LEN-1:0]      modify_vector,
    // status toward execute
    output logic                              full,
    output logic                              empty,
    output logic [mem_ex_pkg::CNT_W-1:0]      count,
    // every slot's modifiable part, for wakeup
    output logic [mem_ex_pkg::MVEC_W-1:0]     old_m_vector,
    // head entry
    output logic [mem_ex_pkg::E_W-1:0]        dout
);

    import mem_ex_pkg::*;

    // storage split in two
    // only the m side is ever rewritten in place
    logic [M_W-1:0]   m_mem [Q_LEN];
    logic [N_W-1:0]   n_mem [Q_LEN];

    // circular pointers, wrap on their own at Q_LEN
    logic [PTR_W-1:0] ptr_wr;
    logic [PTR_W-1:0] ptr_rd;

    // occupancy, 0 to Q_LEN
    logic [CNT_W-1:0] count_q;

    // accepted strobes
    logic             wr_ok;
    logic             rd_ok;

    // flags come straight off the count register
    assign full  = (count_q == CNT_W'(Q_LEN));
    assign empty = (count_q == '0);
    assign count = count_q;

    // a write while full is dropped, a read plus write included
    assign wr_ok = wr && !full;
    // reading an empty queue does nothing
    assign rd_ok = rd && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_wr  <= '0;
            ptr_rd  <= '0;
            count_q <= '0;
            // payload keeps whatever it had
            // only the valid bits drop
            for (int i = 0; i < Q_LEN; i++) begin
                m_mem[i][VALID_BIT] <= 1'b0;
            end
        end else if (clr) begin
            // flush beats wr, rd and any pending wakeup
            ptr_wr  <= '0;
            ptr_rd  <= '0;
            count_q <= '0;
            for (int i = 0; i < Q_LEN; i++) begin
                m_mem[i][VALID_BIT] <= 1'b0;
            end
        end else begin
            // wakeup rewrites of waiting slots
            for (int i = 0; i < Q_LEN; i++) begin
                if (modify_vector[i]) begin
                    m_mem[i] <= new_m_vector[i*M_W +: M_W];
                end
            end

            // write last so it wins on the tail slot
            // the tail slot was free, so no real match there anyway
            if (wr_ok) begin
                m_mem[ptr_wr] <= m_din;
                n_mem[ptr_wr] <= n_din;
                ptr_wr        <= ptr_wr + PTR_W'(1);
            end

            // head just moves, the slot is left as is
            if (rd_ok) begin
                ptr_rd <= ptr_rd + PTR_W'(1);
            end

            // net occupancy change
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                // both or neither, count holds
                default: count_q <= count_q;
            endcase
        end
    end

    // export each slot at i*M_W
    for (genvar i = 0; i < Q_LEN; i++) begin : g_export
        assign old_m_vector[i*M_W +: M_W] = m_mem[i];
    end

    // head entry straight from storage
    // zero while nothing is queued, so it reads 0 out of reset
    assign dout = empty ? '0 : {m_mem[ptr_rd], n_mem[ptr_rd]};

endmodule

/* src/operand_wakeup.sv */
module operand_wakeup (
    // current modifiable parts of all slots
    input  logic [mem_ex_pkg::MVEC_W-1:0]  old_m_vector,
    // entry being written this cycle
    input  logic [mem_ex_pkg::M_W-1:0]     m_din,
    // result bus
    input  logic                           res_valid,
    input  logic [mem_ex_pkg::TAG_W-1:0]   res_tag,
    input  logic [mem_ex_pkg::VAL_W-1:0]   res_val,
    // patched slots, only taken where modify_vector is set
    output logic [mem_ex_pkg::MVEC_W-1:0]  new_m_vector,
    // one bit per physical slot
    output logic [mem_ex_pkg::Q_LEN-1:0]   modify_vector,
    // incoming entry after wakeup
    output logic [mem_ex_pkg::M_W-1:0]     woken_m_din
);

    import mem_ex_pkg::*;

    // one matcher per physical slot
    // indexed by slot, not by queue order
    for (genvar i = 0; i < Q_LEN; i++) begin : g_slot
        wakeup_slot u_slot (
            .m_in      (old_m_vector[i*M_W +: M_W]),
            .res_valid (res_valid),
            .res_tag   (res_tag),
            .res_val   (res_val),
            .m_out     (new_m_vector[i*M_W +: M_W]),
            // hit on slot i means rewrite slot i
            .hit       (modify_vector[i])
        );
    end

    // extra matcher on the incoming entry
    // catches a broadcast in the same cycle as the write
    // its hit is not needed, the write stores m_out regardless
    wakeup_slot u_in_slot (
        .m_in      (m_din),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_val   (res_val),
        .m_out     (woken_m_din),
        .hit       ()
    );

endmodule

/* src/wakeup_slot.sv */
module wakeup_slot (
    // modifiable part of one entry
    input  logic [mem_ex_pkg::M_W-1:0]     m_in,
    // result bus
    input  logic                           res_valid,
    input  logic [mem_ex_pkg::TAG_W-1:0]   res_tag,
    input  logic [mem_ex_pkg::VAL_W-1:0]   res_val,
    // patched modifiable part
    output logic [mem_ex_pkg::M_W-1:0]     m_out,
    // any operand matched
    output logic                           hit
);

    import mem_ex_pkg::*;

    // per-operand match
    logic [NUM_OPS-1:0] op_hit;
    // per-operand fields pulled out of m_in
    logic [NUM_OPS-1:0] op_wait;
    logic [TAG_W-1:0]   op_tag [NUM_OPS];

    // field extraction, operand k at k*OP_W
    for (genvar k = 0; k < NUM_OPS; k++) begin : g_fields
        assign op_wait[k] = m_in[k*OP_W + WAIT_OFS];
        assign op_tag[k]  = m_in[k*OP_W + TAG_OFS +: TAG_W];
        // only a waiting operand can match
        assign op_hit[k]  = res_valid && op_wait[k] && (op_tag[k] == res_tag);
    end

    always_comb begin
        // default is pass-through
        // tag, valid and the other operand stay put
        m_out = m_in;
        for (int k = 0; k < NUM_OPS; k++) begin
            if (op_hit[k]) begin
                // value arrives, operand stops waiting
                m_out[k*OP_W + VAL_OFS +: VAL_W] = res_val;
                m_out[k*OP_W + WAIT_OFS]         = 1'b0;
            end
        end
    end

    // valid bit is not checked
    // a stale free slot may flag a hit, the next write overwrites it
    assign hit = |op_hit;

endmodule

/* src/mem_ex_pkg.sv */
package mem_ex_pkg;

    // queue geometry
    localparam int Q_LEN = 8;
    // slot index width
    localparam int PTR_W = $clog2(Q_LEN);
    // one extra bit so a full queue (8) fits
    localparam int CNT_W = PTR_W + 1;

    // operand layout
    localparam int NUM_OPS = 2;
    localparam int VAL_W = 32;
    // producer tag, compared against the result bus
    localparam int TAG_W = 4;

    // one operand field, low to high is value, tag, wait flag
    localparam int VAL_OFS = 0;
    localparam int TAG_OFS = VAL_OFS + VAL_W;
    localparam int WAIT_OFS = TAG_OFS + TAG_W;
    // 1 + 4 + 32 = 37 bits
    localparam int OP_W = WAIT_OFS + 1;

    // modifiable part
    // operand k starts at k*OP_W, valid bit sits on top
    localparam int M_W = NUM_OPS * OP_W + 1;
    localparam int VALID_BIT = M_W - 1;

    // non-modifiable part, opaque control bits
    localparam int N_W = 32;

    // full entry is {modifiable, non-modifiable}
    // so the modifiable part lands in the upper bits
    localparam int E_W = M_W + N_W;

    // all slots' modifiable parts side by side
    // slot i at i*M_W
    localparam int MVEC_W = Q_LEN * M_W;

endpackage
